// ==== filelist.f ====
hdl/rv32i_pkg.sv
hdl/inst_mem.sv
hdl/instruction_fetch.sv
hdl/instruction_decode.sv
hdl/rv32i_front_end.sv
testbench/front_end_tb.sv

// ==== hdl/inst_mem.sv ====
`timescale 1ns/100ps

module inst_mem #(
	parameter int MEM_WORDS   = 64,
	parameter int MEM_LATENCY = 2
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          prog_we,
	input  logic [$clog2(MEM_WORDS)-1:0]  prog_addr,
	input  rv32i_pkg::rv32i_word          prog_data,
	input  rv32i_pkg::rv32i_word          inst_addr,
	output rv32i_pkg::rv32i_word          inst_rdata,
	output logic                          inst_resp
);
	import rv32i_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);
	localparam int CW = $clog2(MEM_LATENCY + 1);
	localparam logic [CW-1:0] LAT = CW'(MEM_LATENCY);

	rv32i_word       mem [MEM_WORDS];
	rv32i_word       last_addr;
	logic [CW-1:0]   count;
	logic            addr_same;

	// Program port is only open while the core is held in reset
	always_ff @(posedge clk) begin
		if (rst && prog_we) begin
			mem[prog_addr] <= prog_data;
		end
	end

	// Address seen on the previous cycle
	always_ff @(posedge clk) begin
		last_addr <= inst_addr;
	end

	assign addr_same = (inst_addr == last_addr);

	// Cycles the current address has been stable
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (!addr_same) begin
			count <= CW'(1);
		end else if (count != LAT) begin
			count <= count + CW'(1);
		end
	end

	// Response holds as long as the address does not move
	assign inst_resp  = addr_same && (count == LAT);
	assign inst_rdata = mem[inst_addr[AW+1:2]];

endmodule

// ==== hdl/instruction_decode.sv ====
`timescale 1ns/100ps

module instruction_decode (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ma_stall,
	input  rv32i_pkg::rv32i_word      pc_ff,
	input  rv32i_pkg::rv32i_word      instr_ff,
	input  logic                      false_nop,
	output logic                      bubble,
	output rv32i_pkg::rv32i_word      ex_pc,
	output rv32i_pkg::rv32i_word      ex_instr,
	output rv32i_pkg::rv32i_opcode_t  ex_opcode,
	output logic [4:0]                ex_rd,
	output logic [4:0]                ex_rs1,
	output logic [4:0]                ex_rs2,
	output rv32i_pkg::rv32i_word      ex_imm,
	output logic                      ex_nop
);
	import rv32i_pkg::*;

	rv32i_opcode_t opcode;
	rv32i_word     imm;
	logic [4:0]    rs1;
	logic [4:0]    rs2;
	logic          uses_rs1;
	logic          uses_rs2;
	logic          known;

	assign opcode = rv32i_opcode_t'(instr_ff[6:0]);
	assign rs1    = instr_ff[19:15];
	assign rs2    = instr_ff[24:20];

	// Immediate format and register usage per opcode
	always_comb begin
		imm      = '0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		known    = 1'b1;
		case (opcode)
			op_lui, op_auipc: begin
				imm = {instr_ff[31:12], 12'b0};
			end
			op_jal: begin
				imm = {{11{instr_ff[31]}}, instr_ff[31], instr_ff[19:12],
					instr_ff[20], instr_ff[30:21], 1'b0};
			end
			op_jalr, op_load, op_imm: begin
				imm      = {{20{instr_ff[31]}}, instr_ff[31:20]};
				uses_rs1 = 1'b1;
			end
			op_csr: begin
				imm      = {{20{instr_ff[31]}}, instr_ff[31:20]};
				// funct3[2] set selects the uimm form with no register source
				uses_rs1 = !instr_ff[14];
			end
			op_br: begin
				imm      = {{19{instr_ff[31]}}, instr_ff[31], instr_ff[7],
					instr_ff[30:25], instr_ff[11:8], 1'b0};
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			op_store: begin
				imm      = {{20{instr_ff[31]}}, instr_ff[31:25], instr_ff[11:7]};
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			op_reg: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			// The zero word left in IF/ID by reset lands here
			default: known = 1'b0;
		endcase
	end

	// Load-use hazard against the load sitting in ID/EX
	assign bubble = (ex_opcode == op_load) && (ex_rd != 5'd0) &&
		((uses_rs1 && (rs1 == ex_rd)) || (uses_rs2 && (rs2 == ex_rd)));

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst || (!ma_stall && bubble)) begin
			ex_pc     <= rst ? reset_pc : pc_ff;
			ex_instr  <= nop_instr;
			ex_opcode <= op_imm;
			ex_rd     <= '0;
			ex_rs1    <= '0;
			ex_rs2    <= '0;
			ex_imm    <= '0;
			ex_nop    <= 1'b1;
		end else if (!ma_stall) begin
			ex_pc     <= pc_ff;
			ex_instr  <= instr_ff;
			ex_opcode <= opcode;
			ex_rd     <= instr_ff[11:7];
			ex_rs1    <= rs1;
			ex_rs2    <= rs2;
			ex_imm    <= imm;
			ex_nop    <= false_nop || !known;
		end
	end

endmodule

// ==== hdl/instruction_fetch.sv ====
`timescale 1ns/100ps

module instruction_fetch (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ma_stall,
	input  rv32i_pkg::pcmux_sel_t    pcmux_sel,
	input  rv32i_pkg::rv32i_word     alu_out,
	input  logic                     br_taken,
	input  logic                     bubble,
	input  logic                     inst_resp,
	input  rv32i_pkg::rv32i_word     inst_rdata,
	output rv32i_pkg::rv32i_word     inst_addr,
	output rv32i_pkg::rv32i_word     pc_ff,
	output rv32i_pkg::rv32i_word     instr_ff,
	output logic                     false_nop
);
	import rv32i_pkg::*;

	rv32i_word pc;
	rv32i_word pc_in;
	rv32i_word pc_next;
	logic      if_stall;
	logic      pc_load;

	// Branch seen while the memory was still busy
	logic      pend_branch;
	rv32i_word pend_pc;

	assign if_stall  = !inst_resp;
	assign inst_addr = pc;

	// Next PC from the back end select
	always_comb begin
		pc_in = '1;
		case (pcmux_sel)
			pc_plus4:            pc_in = pc + 32'd4;
			rv32i_pkg::alu_out:  pc_in = alu_out;
			alu_mod2:            pc_in = {alu_out[31:1], 1'b0};
			bad_sel:             pc_in = '1;
		endcase
	end

	// A fresh branch wins over an older pending one
	assign pc_next = (pend_branch && !br_taken) ? pend_pc : pc_in;

	assign pc_load = !if_stall && (!(ma_stall || bubble) || br_taken || pend_branch);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (pc_load) begin
			pc <= pc_next;
		end
	end

	// Pending branch flag clears once the PC takes the target
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_branch <= 1'b0;
		end else if (if_stall && br_taken) begin
			pend_branch <= 1'b1;
		end else if (pend_branch && !if_stall) begin
			pend_branch <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (br_taken) begin
			pend_pc <= pc_in;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_ff     <= '0;
			instr_ff  <= '0;
			false_nop <= 1'b0;
		end else if (br_taken || pend_branch) begin
			// Anything behind a redirect is squashed
			pc_ff     <= pc;
			instr_ff  <= nop_instr;
			false_nop <= 1'b1;
		end else if (!bubble && !ma_stall) begin
			pc_ff <= pc;
			if (if_stall) begin
				// Memory still busy so the slot stays empty
				instr_ff  <= nop_instr;
				false_nop <= 1'b1;
			end else begin
				instr_ff  <= inst_rdata;
				false_nop <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/rv32i_front_end.sv ====
`timescale 1ns/100ps

module rv32i_front_end #(
	parameter int MEM_WORDS   = 64,
	parameter int MEM_LATENCY = 2
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          prog_we,
	input  logic [$clog2(MEM_WORDS)-1:0]  prog_addr,
	input  rv32i_pkg::rv32i_word          prog_data,
	input  logic                          ma_stall,
	input  rv32i_pkg::pcmux_sel_t         pcmux_sel,
	input  rv32i_pkg::rv32i_word          alu_out,
	input  logic                          br_taken,
	output rv32i_pkg::rv32i_word          inst_addr,
	output rv32i_pkg::rv32i_word          ex_pc,
	output rv32i_pkg::rv32i_word          ex_instr,
	output rv32i_pkg::rv32i_opcode_t      ex_opcode,
	output logic [4:0]                    ex_rd,
	output logic [4:0]                    ex_rs1,
	output logic [4:0]                    ex_rs2,
	output rv32i_pkg::rv32i_word          ex_imm,
	output logic                          ex_nop
);
	import rv32i_pkg::*;

	rv32i_word inst_rdata;
	logic      inst_resp;
	rv32i_word pc_ff;
	rv32i_word instr_ff;
	logic      false_nop;
	logic      bubble;

	inst_mem #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_inst_mem (
		.clk        (clk),
		.rst        (rst),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.inst_addr  (inst_addr),
		.inst_rdata (inst_rdata),
		.inst_resp  (inst_resp)
	);

	instruction_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.ma_stall   (ma_stall),
		.pcmux_sel  (pcmux_sel),
		.alu_out    (alu_out),
		.br_taken   (br_taken),
		.bubble     (bubble),
		.inst_resp  (inst_resp),
		.inst_rdata (inst_rdata),
		.inst_addr  (inst_addr),
		.pc_ff      (pc_ff),
		.instr_ff   (instr_ff),
		.false_nop  (false_nop)
	);

	instruction_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.ma_stall  (ma_stall),
		.pc_ff     (pc_ff),
		.instr_ff  (instr_ff),
		.false_nop (false_nop),
		.bubble    (bubble),
		.ex_pc     (ex_pc),
		.ex_instr  (ex_instr),
		.ex_opcode (ex_opcode),
		.ex_rd     (ex_rd),
		.ex_rs1    (ex_rs1),
		.ex_rs2    (ex_rs2),
		.ex_imm    (ex_imm),
		.ex_nop    (ex_nop)
	);

endmodule

// ==== hdl/rv32i_pkg.sv ====
package rv32i_pkg;

	// Instruction word and byte address
	typedef logic [31:0] rv32i_word;

	// Next PC source driven by the back end
	typedef enum logic [1:0] {
		pc_plus4 = 2'b00,
		alu_out  = 2'b01,
		alu_mod2 = 2'b10,
		bad_sel  = 2'b11
	} pcmux_sel_t;

	// RV32I major opcodes in bits [6:0] of the instruction
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} rv32i_opcode_t;

	// addi x0, x0, 0
	localparam rv32i_word nop_instr = 32'h0000_0013;

	// First fetch address after reset
	localparam rv32i_word reset_pc = 32'h0000_0000;

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module front_end_tb -o front_end_sim

./obj_dir/front_end_sim > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== testbench/front_end_tb.sv ====
`timescale 1ns/100ps

module front_end_tb;
	import rv32i_pkg::*;

	localparam int MEM_WORDS   = 16;
	localparam int MEM_LATENCY = 2;
	localparam int WAIT_LIMIT  = 200;

	logic                          clk;
	logic                          rst;
	logic                          prog_we;
	logic [$clog2(MEM_WORDS)-1:0]  prog_addr;
	rv32i_word                     prog_data;
	logic                          ma_stall;
	pcmux_sel_t                    pcmux_sel;
	rv32i_word                     alu_res;
	logic                          br_taken;
	rv32i_word                     inst_addr;
	rv32i_word                     ex_pc;
	rv32i_word                     ex_instr;
	rv32i_opcode_t                 ex_opcode;
	logic [4:0]                    ex_rd;
	logic [4:0]                    ex_rs1;
	logic [4:0]                    ex_rs2;
	rv32i_word                     ex_imm;
	logic                          ex_nop;

	// Program image and parsed trace
	rv32i_word     prog [MEM_WORDS];
	byte           cmd_op [$];
	rv32i_word     cmd_a [$];
	rv32i_word     cmd_b [$];
	rv32i_word     cmd_c [$];
	rv32i_word     exp_pc [$];

	// Entries seen leaving ID/EX
	rv32i_word     rec_pc [$];
	rv32i_word     rec_instr [$];
	rv32i_opcode_t rec_opcode [$];
	rv32i_word     rec_imm [$];
	logic [4:0]    rec_rd [$];
	logic [4:0]    rec_rs1 [$];
	logic [4:0]    rec_rs2 [$];

	int mismatches;
	int timeouts;

	rv32i_front_end #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.ma_stall  (ma_stall),
		.pcmux_sel (pcmux_sel),
		.alu_out   (alu_res),
		.br_taken  (br_taken),
		.inst_addr (inst_addr),
		.ex_pc     (ex_pc),
		.ex_instr  (ex_instr),
		.ex_opcode (ex_opcode),
		.ex_rd     (ex_rd),
		.ex_rs1    (ex_rs1),
		.ex_rs2    (ex_rs2),
		.ex_imm    (ex_imm),
		.ex_nop    (ex_nop)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Each entry is recorded once on the edge where it leaves ID/EX
	always @(posedge clk) begin
		if (!rst && !ma_stall && !ex_nop) begin
			rec_pc.push_back(ex_pc);
			rec_instr.push_back(ex_instr);
			rec_opcode.push_back(ex_opcode);
			rec_imm.push_back(ex_imm);
			rec_rd.push_back(ex_rd);
			rec_rs1.push_back(ex_rs1);
			rec_rs2.push_back(ex_rs2);
		end
	end

	// Immediate as the RV32I formats define it
	function automatic rv32i_word expect_imm(input rv32i_word w);
		rv32i_word sx;
		sx = {32{w[31]}};
		case (w[6:0])
			7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
			7'b1101111: return {sx[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
			7'b1100011: return {sx[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
			7'b0100011: return {sx[31:12], w[31:25], w[11:7]};
			7'b0110011: return 32'h0;
			default: return {sx[31:12], w[31:20]};
		endcase
	endfunction

	task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_opcode(input string name, input rv32i_opcode_t got,
		input rv32i_opcode_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got,
		input logic [4:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			mismatches++;
		end
	endtask

	task automatic read_trace();
		int        fd;
		string     line;
		rv32i_word a;
		rv32i_word b;
		rv32i_word c;
		byte       op;
		fd = $fopen("testbench/front_end_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file");
			timeouts++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 3 || line[0] == "#") begin
				continue;
			end
			op = line[0];
			a = '0;
			b = '0;
			c = '0;
			void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c));
			if (op == "W") begin
				prog[a] = b;
			end else if (op == "E") begin
				exp_pc.push_back(a);
			end else begin
				cmd_op.push_back(op);
				cmd_a.push_back(a);
				cmd_b.push_back(b);
				cmd_c.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// Back end redirect once the given PC sits valid in ID/EX
	task automatic branch_at(input rv32i_word sel, input rv32i_word at, input rv32i_word target);
		int cnt;
		cnt = 0;
		while (!(ex_pc == at && !ex_nop) && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= WAIT_LIMIT) begin
			$display("Timed out waiting for the branch at pc %h to reach decode", at);
			timeouts++;
			return;
		end
		pcmux_sel = pcmux_sel_t'(sel[1:0]);
		alu_res   = target;
		br_taken  = 1'b1;
		@(negedge clk);
		br_taken  = 1'b0;
		pcmux_sel = pc_plus4;
	endtask

	task automatic run_commands();
		int i;
		int n;
		for (i = 0; i < cmd_op.size(); i++) begin
			case (cmd_op[i])
				"B": branch_at(cmd_a[i], cmd_b[i], cmd_c[i]);
				"R": repeat (cmd_a[i]) @(negedge clk);
				"S": begin
					ma_stall = 1'b1;
					repeat (cmd_a[i]) @(negedge clk);
					ma_stall = 1'b0;
				end
				"X": begin
					for (n = 0; n < cmd_a[i]; n++) begin
						ma_stall = ($urandom % 4) == 0;
						@(negedge clk);
					end
					ma_stall = 1'b0;
				end
				default: $display("Unknown trace command %c", cmd_op[i]);
			endcase
		end
	endtask

	task automatic check_stream();
		int        i;
		int        cnt;
		rv32i_word w;
		for (i = 0; i < exp_pc.size(); i++) begin
			cnt = 0;
			while (rec_pc.size() == 0 && cnt < WAIT_LIMIT) begin
				@(negedge clk);
				cnt++;
			end
			if (rec_pc.size() == 0) begin
				$display("Timed out waiting for decoded entry %0d at pc %h", i, exp_pc[i]);
				timeouts++;
				return;
			end
			w = prog[exp_pc[i][$clog2(MEM_WORDS)+1:2]];
			check_word("ex_pc", rec_pc.pop_front(), exp_pc[i]);
			check_word("ex_instr", rec_instr.pop_front(), w);
			check_opcode("ex_opcode", rec_opcode.pop_front(), rv32i_opcode_t'(w[6:0]));
			check_word("ex_imm", rec_imm.pop_front(), expect_imm(w));
			check_reg("ex_rd", rec_rd.pop_front(), w[11:7]);
			check_reg("ex_rs1", rec_rs1.pop_front(), w[19:15]);
			check_reg("ex_rs2", rec_rs2.pop_front(), w[24:20]);
		end
	endtask

	initial begin
		int i;
		mismatches = 0;
		timeouts   = 0;
		rst        = 1'b1;
		prog_we    = 1'b0;
		prog_addr  = '0;
		prog_data  = '0;
		ma_stall   = 1'b0;
		pcmux_sel  = pc_plus4;
		alu_res    = '0;
		br_taken   = 1'b0;
		void'($urandom(4431));
		for (i = 0; i < MEM_WORDS; i++) begin
			// Unlisted words become lui x1 with the word index
			prog[i] = (32'(i) << 12) | 32'h0000_00b7;
		end
		read_trace();
		// One program word per reset cycle
		for (i = 0; i < MEM_WORDS; i++) begin
			prog_we   = 1'b1;
			prog_addr = i[$clog2(MEM_WORDS)-1:0];
			prog_data = prog[i];
			@(negedge clk);
		end
		check_word("inst_addr", inst_addr, reset_pc);
		prog_we = 1'b0;
		rst     = 1'b0;
		fork
			run_commands();
			check_stream();
		join
		$display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== testbench/front_end_trace.txt ====
# W word_index data | B sel at_pc target | R cycles | S stall_cycles | X random_stall_cycles
# E pc of the next expected decoded entry, all values hex
W 0 00500093
W 1 ffd08113
W 2 00812183
W 3 00118233
W 4 0040a003
W 5 00312623
W 6 0100006f
W 7 123452b7
W 8 fe208ce3
W 9 00001397
W a 00008067
W b 07f0e413
W c fc2098e3
W d 30009373
W e fe110fa3
W f 402084b3
B 1 18 28
B 2 28 31
B 1 30 0
X c
B 1 18 28
B 2 28 31
S 5
R 40
E 0
E 4
E 8
E c
E 10
E 14
E 18
E 28
E 30
E 0
E 4
E 8
E c
E 10
E 14
E 18
E 28
E 30
E 34
E 38
E 3c
